/* hw/commit_pkg.sv */
package commit_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regid_t;

    // unit that produced a slot's result.
    typedef enum logic [3:0] {
        FU_NONE,
        FU_ALU1,
        FU_ALU2,
        FU_BRU,
        FU_MMU,
        FU_HILO,
        FU_CP0,
        FU_MLT,
        FU_DIV
    } fu_t;

    typedef enum logic [4:0] {
        EX_INT  = 5'd0,
        EX_ADEL = 5'd4,
        EX_ADES = 5'd5,
        EX_SYS  = 5'd8,
        EX_BP   = 5'd9,
        EX_RI   = 5'd10,
        EX_OV   = 5'd12,
        EX_NONE = 5'd31
    } ecode_t;

    localparam regid_t     REG_RA          = 5'd31;
    localparam word_t      EXC_VECTOR      = 32'hBFC00380;
    localparam logic [7:0] STATUS_IM_RESET = 8'hFF;

    localparam int DBG_DEPTH = 8;
    localparam int DBG_PTR_W = $clog2(DBG_DEPTH);

    typedef logic [DBG_PTR_W-1:0] dbg_ptr_t;
    typedef logic [DBG_PTR_W:0]   dbg_cnt_t; // one extra bit so a full queue can be counted.

endpackage

/* hw/commit_unit.sv */
`timescale 1ns/1ps

module commit_unit (
    input  logic                 en1,
    input  commit_pkg::word_t    pc1,
    input  commit_pkg::fu_t      fu1,
    input  commit_pkg::regid_t   target1,
    input  logic                 ri1, ov1, sys1, bp1,
    input  logic                 mem_adel1, mem_ades1,
    input  logic                 en2,
    input  commit_pkg::word_t    pc2,
    input  commit_pkg::fu_t      fu2,
    input  commit_pkg::regid_t   target2,
    input  logic                 ri2, ov2, sys2, bp2,
    input  logic                 mem_adel2, mem_ades2,
    input  commit_pkg::word_t    alu1_result, alu2_result, mmu_out,
    input  commit_pkg::word_t    hilo_result, cp0_result, link_pc,
    input  logic [63:0]          mlt_result, div_result,
    input  logic                 write_hi_hl, write_lo_hl,
    input  commit_pkg::word_t    mem_badvaddr,
    input  logic [5:0]           ext_int,
    input  logic                 eret_req,
    input  logic [7:0]           status_im,
    input  logic                 status_exl,
    input  logic [7:0]           cause_ip,
    input  commit_pkg::word_t    epc,
    output logic                 wr1_en, wr2_en,
    output commit_pkg::regid_t   wr1_addr, wr2_addr,
    output commit_pkg::word_t    wr1_data, wr2_data,
    output logic                 hi_we, lo_we,
    output commit_pkg::word_t    hi_data, lo_data,
    output logic                 exc_en, exc_bd,
    output commit_pkg::word_t    exc_epc, exc_badvaddr,
    output commit_pkg::ecode_t   exc_code,
    output logic                 eret, exc_redirect,
    output commit_pkg::word_t    exc_pc,
    output logic                 ret1_valid, ret1_wen,
    output commit_pkg::word_t    ret1_pc,
    output logic                 ret2_valid, ret2_wen,
    output commit_pkg::word_t    ret2_pc
);
    import commit_pkg::*;

    ecode_t      fault1, fault2;
    logic [7:0]  int_pending;
    logic        int_hit;
    logic        wr_ok1, wr_ok2;
    logic [65:0] hl1, hl2; // {hi_we, lo_we, hi, lo} offered by each slot.

    // first fault of a slot in priority order.
    function automatic ecode_t slot_fault(input logic ri, input logic ov, input logic sys,
                                          input logic bp, input logic adel, input logic ades,
                                          input fu_t fu);
        if (ri) return EX_RI;
        else if (ov) return EX_OV;
        else if (sys) return EX_SYS;
        else if (bp) return EX_BP;
        else if (fu == FU_MMU && adel) return EX_ADEL;
        else if (fu == FU_MMU && ades) return EX_ADES;
        else return EX_NONE;
    endfunction

    function automatic logic writes_gpr(input fu_t fu, input fu_t own_alu);
        return (fu == own_alu) || (fu inside {FU_BRU, FU_MMU, FU_HILO, FU_CP0});
    endfunction

    function automatic word_t unit_result(input fu_t fu, input word_t alu_result);
        case (fu)
            FU_ALU1, FU_ALU2: return alu_result;
            FU_BRU:           return link_pc;
            FU_MMU:           return mmu_out;
            FU_HILO:          return hilo_result;
            FU_CP0:           return cp0_result;
            default:          return '0;
        endcase
    endfunction

    function automatic logic [65:0] hilo_write(input fu_t fu);
        case (fu)
            FU_MLT:  return {2'b11, mlt_result};
            FU_DIV:  return {2'b11, div_result};
            FU_HILO: return {write_hi_hl, write_lo_hl, hilo_result, hilo_result};
            default: return '0;
        endcase
    endfunction

    // ##################################################################
    // exception selection
    // ##################################################################

    assign fault1 = en1 ? slot_fault(ri1, ov1, sys1, bp1, mem_adel1, mem_ades1, fu1) : EX_NONE;
    assign fault2 = en2 ? slot_fault(ri2, ov2, sys2, bp2, mem_adel2, mem_ades2, fu2) : EX_NONE;

    assign int_pending = ({ext_int, 2'b00} | cause_ip) & status_im;
    assign int_hit     = en1 && !status_exl && (int_pending != 8'd0);

    always_comb begin
        exc_en       = 1'b0;
        exc_bd       = 1'b0;
        exc_epc      = '0;
        exc_badvaddr = '0;
        exc_code     = EX_NONE;
        if (int_hit) begin
            exc_en   = 1'b1;
            exc_epc  = pc1 + 32'd4; // slot 1 completes before the interrupt.
            exc_code = EX_INT;
        end else if (fault1 != EX_NONE) begin
            exc_en   = 1'b1;
            exc_epc  = pc1;
            exc_code = fault1;
            if (fault1 inside {EX_ADEL, EX_ADES}) exc_badvaddr = mem_badvaddr;
        end else if (fault2 != EX_NONE) begin
            exc_en   = 1'b1;
            exc_bd   = (fu1 == FU_BRU);
            exc_epc  = (fu1 == FU_BRU) ? pc2 - 32'd4 : pc2; // restart at the branch.
            exc_code = fault2;
            if (fault2 inside {EX_ADEL, EX_ADES}) exc_badvaddr = mem_badvaddr;
        end
    end

    assign eret         = eret_req && !exc_en;
    assign exc_redirect = exc_en || eret;
    assign exc_pc       = exc_en ? EXC_VECTOR : epc;

    // ##################################################################
    // write cancelling and result steering
    // ##################################################################

    assign wr_ok1 = en1 && (fault1 == EX_NONE);
    assign wr_ok2 = en2 && !exc_en;

    always_comb begin
        wr1_addr = (fu1 == FU_BRU) ? REG_RA : target1;
        wr1_data = unit_result(fu1, alu1_result);
        wr1_en   = wr_ok1 && writes_gpr(fu1, FU_ALU1) && (wr1_addr != 5'd0);
        wr2_addr = (fu2 == FU_BRU) ? REG_RA : target2;
        wr2_data = unit_result(fu2, alu2_result);
        wr2_en   = wr_ok2 && writes_gpr(fu2, FU_ALU2) && (wr2_addr != 5'd0);
        hl1      = wr_ok1 ? hilo_write(fu1) : '0;
        hl2      = wr_ok2 ? hilo_write(fu2) : '0;
    end

    // each half is taken from the younger slot when it writes that half.
    assign hi_we   = hl1[65] || hl2[65];
    assign lo_we   = hl1[64] || hl2[64];
    assign hi_data = hl2[65] ? hl2[63:32] : hl1[63:32];
    assign lo_data = hl2[64] ? hl2[31:0] : hl1[31:0];

    assign ret1_valid = wr_ok1;
    assign ret1_pc    = pc1;
    assign ret1_wen   = wr1_en;
    assign ret2_valid = wr_ok2;
    assign ret2_pc    = pc2;
    assign ret2_wen   = wr2_en;

endmodule

/* hw/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [5:0]           ext_int,
    input  logic                 exc_en,
    input  logic                 exc_bd,
    input  commit_pkg::word_t    exc_epc,
    input  commit_pkg::word_t    exc_badvaddr,
    input  commit_pkg::ecode_t   exc_code,
    input  logic                 eret,
    output logic [7:0]           status_im,
    output logic                 status_exl,
    output logic [7:0]           cause_ip,
    output logic                 cause_bd,
    output commit_pkg::ecode_t   cause_code,
    output commit_pkg::word_t    epc,
    output commit_pkg::word_t    badvaddr
);
    import commit_pkg::*;

    logic [5:0] ip_hw; // hardware interrupt lines IP7..IP2.

    // the two software interrupt bits stay clear since nothing writes them.
    assign cause_ip = {ip_hw, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= STATUS_IM_RESET;
            status_exl <= 1'b0;
            ip_hw      <= '0;
            cause_bd   <= 1'b0;
            cause_code <= EX_NONE;
            epc        <= '0;
            badvaddr   <= '0;
        end else begin
            ip_hw <= ext_int; // sampled every cycle.
            if (exc_en) begin
                status_exl <= 1'b1;
                cause_bd   <= exc_bd;
                cause_code <= exc_code;
                epc        <= exc_epc;
                badvaddr   <= exc_badvaddr;
            end else if (eret) begin
                status_exl <= 1'b0; // back to the interrupted program.
            end
        end
    end

endmodule

/* hw/arch_regs.sv */
`timescale 1ns/1ps

module arch_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr1_en,
    input  commit_pkg::regid_t   wr1_addr,
    input  commit_pkg::word_t    wr1_data,
    input  logic                 wr2_en,
    input  commit_pkg::regid_t   wr2_addr,
    input  commit_pkg::word_t    wr2_data,
    input  logic                 hi_we,
    input  logic                 lo_we,
    input  commit_pkg::word_t    hi_data,
    input  commit_pkg::word_t    lo_data,
    input  commit_pkg::regid_t   rd_addr,
    output commit_pkg::word_t    rd_data,
    output commit_pkg::word_t    hi,
    output commit_pkg::word_t    lo
);
    import commit_pkg::*;

    word_t gpr [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                gpr[i] <= '0;
            end
            hi <= '0;
            lo <= '0;
        end else begin
            if (wr1_en && wr1_addr != 5'd0) gpr[wr1_addr] <= wr1_data;
            // the younger slot is written last so it wins on a clash.
            if (wr2_en && wr2_addr != 5'd0) gpr[wr2_addr] <= wr2_data;
            if (hi_we) hi <= hi_data;
            if (lo_we) lo <= lo_data;
        end
    end

    assign rd_data = (rd_addr == 5'd0) ? '0 : gpr[rd_addr];

endmodule

/* hw/debug_queue.sv */
`timescale 1ns/1ps

module debug_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ret1_valid,
    input  commit_pkg::word_t    ret1_pc,
    input  logic                 ret1_wen,
    input  logic                 ret2_valid,
    input  commit_pkg::word_t    ret2_pc,
    input  logic                 ret2_wen,
    input  commit_pkg::regid_t   wr1_addr,
    input  commit_pkg::word_t    wr1_data,
    input  commit_pkg::regid_t   wr2_addr,
    input  commit_pkg::word_t    wr2_data,
    output logic                 debug_full,
    output logic                 debug_wb_valid,
    output commit_pkg::word_t    debug_wb_pc,
    output logic                 debug_wb_wen,
    output commit_pkg::regid_t   debug_wb_wnum,
    output commit_pkg::word_t    debug_wb_wdata
);
    import commit_pkg::*;

    word_t      pc_q    [DBG_DEPTH];
    logic       wen_q   [DBG_DEPTH];
    regid_t     wnum_q  [DBG_DEPTH];
    word_t      wdata_q [DBG_DEPTH];
    dbg_ptr_t   wr_ptr, wr_ptr2, rd_ptr;
    dbg_cnt_t   count;
    logic [1:0] n_push;

    assign n_push     = {1'b0, ret1_valid} + {1'b0, ret2_valid};
    assign wr_ptr2    = wr_ptr + dbg_ptr_t'(ret1_valid); // slot 2 lands right behind slot 1.
    assign debug_full = count > dbg_cnt_t'(DBG_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + dbg_ptr_t'(n_push);
            rd_ptr <= rd_ptr + dbg_ptr_t'(debug_wb_valid);
            count  <= count + dbg_cnt_t'(n_push) - dbg_cnt_t'(debug_wb_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (ret1_valid) begin
            pc_q[wr_ptr]    <= ret1_pc;
            wen_q[wr_ptr]   <= ret1_wen;
            wnum_q[wr_ptr]  <= wr1_addr;
            wdata_q[wr_ptr] <= wr1_data;
        end
        if (ret2_valid) begin
            pc_q[wr_ptr2]    <= ret2_pc;
            wen_q[wr_ptr2]   <= ret2_wen;
            wnum_q[wr_ptr2]  <= wr2_addr;
            wdata_q[wr_ptr2] <= wr2_data;
        end
    end

    // the head is shown for one cycle and then dropped.
    assign debug_wb_valid = (count != '0);
    assign debug_wb_pc    = pc_q[rd_ptr];
    assign debug_wb_wen   = wen_q[rd_ptr];
    assign debug_wb_wnum  = wnum_q[rd_ptr];
    assign debug_wb_wdata = wdata_q[rd_ptr];

endmodule

/* hw/commit_top.sv */
`timescale 1ns/1ps

module commit_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en1, en2,
    input  commit_pkg::word_t    pc1, pc2,
    input  commit_pkg::fu_t      fu1, fu2,
    input  commit_pkg::regid_t   target1, target2,
    input  logic                 ri1, ov1, sys1, bp1, mem_adel1, mem_ades1,
    input  logic                 ri2, ov2, sys2, bp2, mem_adel2, mem_ades2,
    input  commit_pkg::word_t    alu1_result, alu2_result, mmu_out,
    input  commit_pkg::word_t    hilo_result, cp0_result, link_pc,
    input  logic [63:0]          mlt_result, div_result,
    input  logic                 write_hi_hl, write_lo_hl,
    input  commit_pkg::word_t    mem_badvaddr,
    input  logic [5:0]           ext_int,
    input  logic                 eret_req,
    input  commit_pkg::regid_t   rd_addr,
    output commit_pkg::word_t    rd_data,
    output commit_pkg::word_t    hi, lo,
    output commit_pkg::word_t    epc, badvaddr,
    output commit_pkg::ecode_t   cause_code,
    output logic                 cause_bd,
    output logic                 status_exl,
    output logic                 exc_redirect,
    output commit_pkg::word_t    exc_pc,
    output logic                 eret,
    output logic                 debug_full,
    output logic                 debug_wb_valid,
    output commit_pkg::word_t    debug_wb_pc,
    output logic                 debug_wb_wen,
    output commit_pkg::regid_t   debug_wb_wnum,
    output commit_pkg::word_t    debug_wb_wdata
);
    import commit_pkg::*;

    logic [7:0] status_im, cause_ip;
    logic       wr1_en, wr2_en, hi_we, lo_we;
    regid_t     wr1_addr, wr2_addr;
    word_t      wr1_data, wr2_data, hi_data, lo_data;
    logic       exc_en, exc_bd;
    word_t      exc_epc, exc_badvaddr;
    ecode_t     exc_code;
    logic       ret1_valid, ret1_wen, ret2_valid, ret2_wen;
    word_t      ret1_pc, ret2_pc;

    commit_unit i_unit (.*);

    cp0_regs i_cp0 (.*);

    arch_regs i_regs (.*);

    debug_queue i_dbg (.*);

endmodule

/* bench/tb_commit.sv */
`timescale 1ns/1ps

module tb_commit;
    import commit_pkg::*;

    localparam int MAX_CYCLES = 2000; // all tests together run for roughly 100 cycles.

    typedef struct packed {
        word_t  pc;
        logic   wen;
        regid_t wnum;
        word_t  wdata;
    } trace_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        en1, en2;
    word_t       pc1, pc2;
    fu_t         fu1, fu2;
    regid_t      target1, target2;
    logic        ri1, ov1, sys1, bp1, mem_adel1, mem_ades1;
    logic        ri2, ov2, sys2, bp2, mem_adel2, mem_ades2;
    word_t       alu1_result, alu2_result, mmu_out, hilo_result, cp0_result, link_pc;
    logic [63:0] mlt_result, div_result;
    logic        write_hi_hl, write_lo_hl;
    word_t       mem_badvaddr;
    logic [5:0]  ext_int;
    logic        eret_req;
    regid_t      rd_addr;
    word_t       rd_data, hi, lo, epc, badvaddr, exc_pc;
    ecode_t      cause_code;
    logic        cause_bd, status_exl, exc_redirect, eret;
    logic        debug_full, debug_wb_valid, debug_wb_wen;
    word_t       debug_wb_pc, debug_wb_wdata;
    regid_t      debug_wb_wnum;

    trace_t trace_q [$]; // retirements the trace port still owes.
    trace_t head;
    int     n_pushed = 0; // entries queued this cycle that the DUT has not written yet.
    int     occupancy;
    int     full_seen = 0; // cycles in which the DUT raised debug_full.
    int     errors = 0;
    int     cycles = 0;

    commit_top i_dut (.*);

    always #4 clk = ~clk;

    // ####################################################################
    // helpers
    // ####################################################################

    task automatic show_mismatch(input string name, input word_t got, input word_t want);
        errors++;
        $display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
    endtask

    task automatic show_failure(input string what);
        errors++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    task automatic clear_inputs();
        {en1, en2, eret_req, write_hi_hl, write_lo_hl} <= '0;
        {ri1, ov1, sys1, bp1, mem_adel1, mem_ades1} <= '0;
        {ri2, ov2, sys2, bp2, mem_adel2, mem_ades2} <= '0;
        {pc1, pc2, target1, target2, ext_int, mem_badvaddr} <= '0;
        {alu1_result, alu2_result, mmu_out, hilo_result, cp0_result, link_pc} <= '0;
        {mlt_result, div_result} <= '0;
        fu1 <= FU_NONE;
        fu2 <= FU_NONE;
        n_pushed = 0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        clear_inputs();
    endtask

    task automatic set_slot1(input fu_t fu, input word_t pc, input regid_t target);
        en1 <= 1'b1;
        fu1 <= fu;
        pc1 <= pc;
        target1 <= target;
    endtask

    task automatic set_slot2(input fu_t fu, input word_t pc, input regid_t target);
        en2 <= 1'b1;
        fu2 <= fu;
        pc2 <= pc;
        target2 <= target;
    endtask

    task automatic expect_trace(input word_t pc, input logic wen, input regid_t wnum,
                                input word_t wdata);
        trace_q.push_back({pc, wen, wnum, wdata});
        n_pushed++;
    endtask

    task automatic check_reg(input regid_t addr, input word_t want);
        next_cycle();
        rd_addr <= addr;
        @(negedge clk);
        assert (rd_data === want)
            else show_mismatch($sformatf("rd_data[%0d]", addr), rd_data, want);
    endtask

    task automatic check_hilo(input word_t want_hi, input word_t want_lo);
        next_cycle();
        @(negedge clk);
        assert (hi === want_hi) else show_mismatch("hi", hi, want_hi);
        assert (lo === want_lo) else show_mismatch("lo", lo, want_lo);
    endtask

    task automatic check_redirect();
        @(negedge clk);
        assert (exc_redirect === 1'b1) else show_failure("no redirect for an exception");
        assert (exc_pc === EXC_VECTOR) else show_mismatch("exc_pc", exc_pc, EXC_VECTOR);
    endtask

    task automatic check_exception(input ecode_t code, input word_t want_epc, input logic bd);
        next_cycle();
        @(negedge clk);
        assert (cause_code === code) else show_mismatch("cause_code", 32'(cause_code), 32'(code));
        assert (epc === want_epc) else show_mismatch("epc", epc, want_epc);
        assert (cause_bd === bd) else show_mismatch("cause_bd", 32'(cause_bd), 32'(bd));
        assert (status_exl === 1'b1) else show_mismatch("status_exl", 32'(status_exl), 32'h1);
    endtask

    task automatic do_eret(input word_t want_epc);
        next_cycle();
        eret_req <= 1'b1;
        @(negedge clk);
        assert (eret === 1'b1 && exc_redirect === 1'b1) else show_failure("eret was not taken");
        assert (exc_pc === want_epc) else show_mismatch("exc_pc", exc_pc, want_epc);
        next_cycle();
        @(negedge clk);
        assert (status_exl === 1'b0) else show_mismatch("status_exl", 32'(status_exl), 32'h0);
    endtask

    // ####################################################################
    // directed tests
    // ####################################################################

    task automatic test_dual_writes();
        word_t d [6];
        foreach (d[i]) d[i] = $urandom;
        next_cycle();
        set_slot1(FU_ALU1, 32'h1000, 5'd5);
        set_slot2(FU_ALU2, 32'h1004, 5'd6);
        alu1_result <= d[0];
        alu2_result <= d[1];
        expect_trace(32'h1000, 1'b1, 5'd5, d[0]);
        expect_trace(32'h1004, 1'b1, 5'd6, d[1]);
        next_cycle();
        set_slot1(FU_MMU, 32'h1008, 5'd7);
        set_slot2(FU_HILO, 32'h100c, 5'd8); // a move from HI/LO touches only the GPR.
        mmu_out <= d[2];
        hilo_result <= d[3];
        expect_trace(32'h1008, 1'b1, 5'd7, d[2]);
        expect_trace(32'h100c, 1'b1, 5'd8, d[3]);
        next_cycle();
        set_slot1(FU_CP0, 32'h1010, 5'd9);
        set_slot2(FU_CP0, 32'h1014, 5'd10);
        cp0_result <= d[4];
        expect_trace(32'h1010, 1'b1, 5'd9, d[4]);
        expect_trace(32'h1014, 1'b1, 5'd10, d[4]);
        next_cycle();
        set_slot1(FU_ALU1, 32'h1018, 5'd11);
        set_slot2(FU_ALU2, 32'h101c, 5'd11);
        alu1_result <= d[5];
        alu2_result <= ~d[5];
        expect_trace(32'h1018, 1'b1, 5'd11, d[5]);
        expect_trace(32'h101c, 1'b1, 5'd11, ~d[5]);
        next_cycle();
        set_slot1(FU_ALU1, 32'h1020, 5'd0);
        alu1_result <= d[0];
        expect_trace(32'h1020, 1'b0, 5'd0, d[0]);
        check_reg(5'd5, d[0]);
        check_reg(5'd6, d[1]);
        check_reg(5'd7, d[2]);
        check_reg(5'd8, d[3]);
        check_reg(5'd9, d[4]);
        check_reg(5'd10, d[4]);
        check_reg(5'd11, ~d[5]);
        check_reg(5'd0, 32'h0);
    endtask

    task automatic test_branch_link();
        word_t link;
        link = $urandom;
        next_cycle();
        set_slot1(FU_BRU, 32'h2000, 5'd3);
        link_pc <= link;
        expect_trace(32'h2000, 1'b1, REG_RA, link);
        check_reg(REG_RA, link);
        check_reg(5'd3, 32'h0);
    endtask

    task automatic test_hilo();
        logic [63:0] m, q, qn;
        word_t       x;
        m = {$urandom, $urandom};
        q = {$urandom, $urandom};
        qn = ~q;
        x = $urandom;
        next_cycle();
        set_slot1(FU_MLT, 32'h3000, 5'd0);
        mlt_result <= m;
        expect_trace(32'h3000, 1'b0, 5'd0, 32'h0);
        check_hilo(m[63:32], m[31:0]);
        next_cycle();
        set_slot1(FU_DIV, 32'h3004, 5'd0);
        div_result <= q;
        expect_trace(32'h3004, 1'b0, 5'd0, 32'h0);
        check_hilo(q[63:32], q[31:0]);
        next_cycle();
        set_slot1(FU_HILO, 32'h3008, 5'd0);
        hilo_result <= x;
        write_lo_hl <= 1'b1;
        expect_trace(32'h3008, 1'b0, 5'd0, 32'h0);
        check_hilo(q[63:32], x);
        next_cycle();
        set_slot1(FU_MLT, 32'h300c, 5'd0);
        set_slot2(FU_DIV, 32'h3010, 5'd0);
        mlt_result <= m;
        div_result <= qn;
        expect_trace(32'h300c, 1'b0, 5'd0, 32'h0);
        expect_trace(32'h3010, 1'b0, 5'd0, 32'h0);
        check_hilo(qn[63:32], qn[31:0]);
    endtask

    task automatic test_exceptions();
        word_t link, bad;
        link = $urandom;
        bad = $urandom;
        next_cycle();
        set_slot1(FU_BRU, 32'h4000, 5'd0);
        set_slot2(FU_ALU2, 32'h4004, 5'd12); // overflow in the delay slot.
        link_pc <= link;
        alu2_result <= bad;
        ov2 <= 1'b1;
        expect_trace(32'h4000, 1'b1, REG_RA, link);
        check_redirect();
        check_exception(EX_OV, 32'h4000, 1'b1);
        check_reg(REG_RA, link);
        check_reg(5'd12, 32'h0);
        do_eret(32'h4000);
        next_cycle();
        set_slot1(FU_ALU1, 32'h4100, 5'd13);
        set_slot2(FU_ALU2, 32'h4104, 5'd14);
        alu1_result <= bad;
        alu2_result <= bad;
        ri1 <= 1'b1;
        check_redirect();
        check_exception(EX_RI, 32'h4100, 1'b0);
        check_reg(5'd13, 32'h0);
        check_reg(5'd14, 32'h0);
        do_eret(32'h4100);
        next_cycle();
        set_slot1(FU_MMU, 32'h4200, 5'd15);
        mmu_out <= bad;
        mem_ades1 <= 1'b1;
        mem_badvaddr <= bad;
        check_redirect();
        check_exception(EX_ADES, 32'h4200, 1'b0);
        assert (badvaddr === bad) else show_mismatch("badvaddr", badvaddr, bad);
        check_reg(5'd15, 32'h0);
        do_eret(32'h4200);
    endtask

    task automatic test_interrupt();
        word_t d1, d2;
        d1 = $urandom;
        d2 = $urandom;
        next_cycle();
        set_slot1(FU_ALU1, 32'h5000, 5'd16);
        set_slot2(FU_ALU2, 32'h5004, 5'd18);
        alu1_result <= d1;
        alu2_result <= d2;
        ext_int <= 6'b000001;
        expect_trace(32'h5000, 1'b1, 5'd16, d1); // slot 1 completes ahead of the interrupt.
        check_redirect();
        check_exception(EX_INT, 32'h5004, 1'b0);
        next_cycle();
        set_slot1(FU_ALU1, 32'h5100, 5'd17);
        alu1_result <= d2;
        ext_int <= 6'b000010;
        expect_trace(32'h5100, 1'b1, 5'd17, d2);
        @(negedge clk);
        assert (exc_redirect === 1'b0)
            else show_failure("an interrupt was taken while EXL was set");
        check_reg(5'd16, d1);
        check_reg(5'd17, d2);
        check_reg(5'd18, 32'h0);
        do_eret(32'h5004);
    endtask

    task automatic test_trace_burst();
        int     sent;
        word_t  pc, a, b;
        regid_t t1, t2;
        sent = 0;
        pc = 32'h6000;
        while (sent < 20) begin
            next_cycle();
            // with fewer than two free entries the slots stay idle this cycle.
            if (DBG_DEPTH - trace_q.size() >= 2) begin
                a = $urandom;
                b = $urandom;
                t1 = (sent == 3) ? 5'd0 : regid_t'($urandom);
                t2 = regid_t'($urandom);
                set_slot1(FU_ALU1, pc, t1);
                set_slot2(FU_ALU2, pc + 32'd4, t2);
                alu1_result <= a;
                alu2_result <= b;
                expect_trace(pc, t1 != 5'd0, t1, a);
                expect_trace(pc + 32'd4, t2 != 5'd0, t2, b);
                pc = pc + 32'd8;
                sent++;
            end
        end
        next_cycle();
        assert (full_seen > 0) else show_failure("debug_full never rose during the burst");
    endtask

    // ####################################################################
    // trace monitor and run control
    // ####################################################################

    always @(negedge clk) begin
        if (!reset) begin
            occupancy = trace_q.size() - n_pushed;
            if (debug_full === 1'b1) full_seen++;
            assert (debug_full === ((DBG_DEPTH - occupancy) < 2))
                else show_mismatch("debug_full", 32'(debug_full),
                                   32'((DBG_DEPTH - occupancy) < 2));
            assert (!(debug_full && (en1 || en2)))
                else show_failure("slots were offered while the debug queue was full");
            if (debug_wb_valid) begin
                assert (trace_q.size() != 0)
                    else show_failure("the trace port emitted a retirement that was not expected");
                if (trace_q.size() != 0) begin
                    head = trace_q.pop_front();
                    assert (debug_wb_pc === head.pc)
                        else show_mismatch("debug_wb_pc", debug_wb_pc, head.pc);
                    assert (debug_wb_wen === head.wen)
                        else show_mismatch("debug_wb_wen", 32'(debug_wb_wen), 32'(head.wen));
                    if (head.wen) begin
                        assert (debug_wb_wnum === head.wnum)
                            else show_mismatch("debug_wb_wnum", 32'(debug_wb_wnum), 32'(head.wnum));
                        assert (debug_wb_wdata === head.wdata)
                            else show_mismatch("debug_wb_wdata", debug_wb_wdata, head.wdata);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d errors so far", cycles, errors);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(71017));
        reset <= 1'b1;
        rd_addr <= '0;
        clear_inputs();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_dual_writes();
        test_branch_link();
        test_hilo();
        test_exceptions();
        test_interrupt();
        test_trace_burst();
        while (trace_q.size() != 0) @(negedge clk); // let the trace port drain.
        repeat (2) @(posedge clk); // the monitor looks once more at an empty trace port.
        $display("errors: %0d, cycles: %0d", errors, cycles);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* dual_commit.f */
hw/commit_pkg.sv
hw/commit_unit.sv
hw/cp0_regs.sv
hw/arch_regs.sv
hw/debug_queue.sv
hw/commit_top.sv
bench/tb_commit.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_commit
FILELIST = dual_commit.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
